/* common/mem_pkg.sv */
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_WIDTH     = 32;
    localparam int LANES          = 4;                   // Bytes per word
    localparam int BYTE_OFF_WIDTH = 2;
    localparam int BYTE_WIDTH     = DATA_WIDTH / LANES;
    localparam int HALF_WIDTH     = 2 * BYTE_WIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [LANES-1:0]      byte_en_t;            // Bit 3 is the top byte

    // Same codes for loads and stores, bit 2 marks unsigned
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_op_t;

    // Sign extension only for the two signed narrow loads
    function automatic logic op_signed(input mem_op_t op);
        return (op == MEM_B) || (op == MEM_H);
    endfunction

endpackage

/* hw/mem_stage/mem_access_ctrl.sv */
module mem_access_ctrl #(
    parameter int WORDS = 32
) (
    input  logic                                      mem_read,
    input  logic                                      mem_write,
    input  mem_pkg::mem_op_t                          mem_op,
    input  logic [$clog2(WORDS)+mem_pkg::BYTE_OFF_WIDTH-1:0] addr,
    input  mem_pkg::word_t                            store_data,
    output logic [$clog2(WORDS)-1:0]                  word_addr,
    output logic [mem_pkg::BYTE_OFF_WIDTH-1:0]        byte_off,
    output mem_pkg::byte_en_t                         wen,
    output mem_pkg::word_t                            wdata,
    output logic                                      misalign
);

    localparam int WA_WIDTH   = $clog2(WORDS);
    localparam int ADDR_WIDTH = WA_WIDTH + mem_pkg::BYTE_OFF_WIDTH;

    logic              bad_align;
    mem_pkg::byte_en_t lane_mask;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign word_addr = addr[ADDR_WIDTH-1:mem_pkg::BYTE_OFF_WIDTH];
    assign byte_off  = addr[mem_pkg::BYTE_OFF_WIDTH-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Size decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        bad_align = 1'b0;
        lane_mask = '0;
        case (mem_op)
            mem_pkg::MEM_B, mem_pkg::MEM_BU:
            begin
                lane_mask = mem_pkg::byte_en_t'(1) << byte_off;   // Any offset is fine
            end
            mem_pkg::MEM_H, mem_pkg::MEM_HU:
            begin
                bad_align = byte_off[0];
                lane_mask = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            mem_pkg::MEM_W:
            begin
                bad_align = |byte_off;
                lane_mask = '1;
            end
            default:
            begin
                // Unused codes behave as a word access
                bad_align = |byte_off;
                lane_mask = '1;
            end
        endcase
    end

    // Only flag an actual access
    assign misalign = (mem_read || mem_write) && bad_align;

    // Nothing written on a misaligned store
    assign wen = (mem_write && !bad_align) ? lane_mask : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store data lane replication
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (mem_op)
            mem_pkg::MEM_B, mem_pkg::MEM_BU:
            begin
                wdata = {mem_pkg::LANES{store_data[mem_pkg::BYTE_WIDTH-1:0]}};
            end
            mem_pkg::MEM_H, mem_pkg::MEM_HU:
            begin
                wdata = {(mem_pkg::LANES / 2){store_data[mem_pkg::HALF_WIDTH-1:0]}};
            end
            default:
            begin
                wdata = store_data;   // Word, as is
            end
        endcase
    end

endmodule

/* hw/mem_stage/data_ram.sv */
module data_ram #(
    parameter int WORDS = 32
) (
    input  logic                     clk,
    input  mem_pkg::byte_en_t        wen,
    input  logic [$clog2(WORDS)-1:0] addr,
    input  mem_pkg::word_t           wdata,
    output mem_pkg::word_t           rdata,
    input  logic [$clog2(WORDS)-1:0] test_addr,
    output mem_pkg::word_t           test_data
);

    localparam int BW = mem_pkg::BYTE_WIDTH;

    mem_pkg::word_t mem [WORDS];   // Contents undefined until written

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte lane writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < mem_pkg::LANES; lane++)
        begin
            if (wen[lane])
            begin
                mem[addr][lane*BW +: BW] <= wdata[lane*BW +: BW];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Both asynchronous, new data visible the cycle after a write
    assign rdata     = mem[addr];
    assign test_data = mem[test_addr];   // Debug view

endmodule

/* hw/mem_stage/load_align.sv */
module load_align (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               mem_read,
    input  mem_pkg::mem_op_t                   mem_op,
    input  logic [mem_pkg::BYTE_OFF_WIDTH-1:0] byte_off,
    input  logic                               misalign,
    input  mem_pkg::word_t                     rdata,
    output mem_pkg::word_t                     wb_data,
    output logic                               wb_valid,
    output logic                               wb_fault
);

    localparam int DW = mem_pkg::DATA_WIDTH;
    localparam int BW = mem_pkg::BYTE_WIDTH;
    localparam int HW = mem_pkg::HALF_WIDTH;

    logic [BW-1:0]  sel_byte;
    logic [HW-1:0]  sel_half;
    logic           sign_ext;
    mem_pkg::word_t load_val;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sel_byte = rdata[byte_off*BW +: BW];
    assign sel_half = byte_off[1] ? rdata[DW-1 -: HW] : rdata[HW-1:0];   // Bit 0 ignored
    assign sign_ext = mem_pkg::op_signed(mem_op);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Extension
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (mem_op)
            mem_pkg::MEM_B, mem_pkg::MEM_BU:
            begin
                load_val = {{(DW - BW){sign_ext && sel_byte[BW-1]}}, sel_byte};
            end
            mem_pkg::MEM_H, mem_pkg::MEM_HU:
            begin
                load_val = {{(DW - HW){sign_ext && sel_half[HW-1]}}, sel_half};
            end
            default:
            begin
                load_val = rdata;   // Word load
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_data  <= '0;
            wb_valid <= 1'b0;
            wb_fault <= 1'b0;
        end
        else
        begin
            wb_valid <= mem_read;             // Exactly one cycle per load
            wb_fault <= mem_read && misalign;
            // Zero on fault and on non-load cycles
            if (mem_read && !misalign)
            begin
                wb_data <= load_val;
            end
            else
            begin
                wb_data <= '0;
            end
        end
    end

endmodule

/* hw/mem_stage/mem_stage.sv */
module mem_stage #(
    parameter int WORDS = 32
) (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             mem_read,
    input  logic                                             mem_write,
    input  mem_pkg::mem_op_t                                 mem_op,
    input  logic [$clog2(WORDS)+mem_pkg::BYTE_OFF_WIDTH-1:0] addr,
    input  mem_pkg::word_t                                   store_data,
    input  logic [$clog2(WORDS)-1:0]                         test_addr,
    output mem_pkg::word_t                                   test_data,
    output mem_pkg::word_t                                   wb_data,
    output logic                                             wb_valid,
    output logic                                             wb_fault
);

    localparam int WA_WIDTH = $clog2(WORDS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [WA_WIDTH-1:0]                word_addr;
    logic [mem_pkg::BYTE_OFF_WIDTH-1:0] byte_off;
    mem_pkg::byte_en_t                  wen;
    mem_pkg::word_t                     wdata;
    mem_pkg::word_t                     rdata;
    logic                               misalign;

    // Request decode
    mem_access_ctrl #(
        .WORDS      (WORDS)
    ) u_ctrl (
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_op     (mem_op),
        .addr       (addr),
        .store_data (store_data),
        .word_addr  (word_addr),
        .byte_off   (byte_off),
        .wen        (wen),
        .wdata      (wdata),
        .misalign   (misalign)
    );

    data_ram #(
        .WORDS      (WORDS)
    ) u_ram (
        .clk        (clk),
        .wen        (wen),
        .addr       (word_addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .test_addr  (test_addr),
        .test_data  (test_data)
    );

    // Load result, one cycle later
    load_align u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_op     (mem_op),
        .byte_off   (byte_off),
        .misalign   (misalign),
        .rdata      (rdata),
        .wb_data    (wb_data),
        .wb_valid   (wb_valid),
        .wb_fault   (wb_fault)
    );

endmodule

/* testbench/mem_stage_assert.sv */
module mem_stage_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              mem_read,
    input logic              mem_write,
    input logic              wb_valid,
    input logic              misalign,
    input mem_pkg::byte_en_t wen
);

    timeunit 1ns;
    timeprecision 1ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and result properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("read and write strobes high in the same cycle");

    // Exactly one cycle of load latency
    valid_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == $past(mem_read))
        else $error("wb_valid does not follow mem_read by one cycle");

    no_write_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
        misalign |-> (wen == '0))
        else $error("byte enables active on a misaligned access");

endmodule

bind mem_stage mem_stage_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .wb_valid  (wb_valid),
    .misalign  (misalign),
    .wen       (wen)
);

/* testbench/tb_mem_stage.sv */
module tb_mem_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS      = 32;
    localparam int WA_W       = $clog2(WORDS);
    localparam int ADDR_W     = WA_W + mem_pkg::BYTE_OFF_WIDTH;
    localparam int CLK_PERIOD = 20;

    typedef struct packed {
        logic              rd;
        logic              wr;
        mem_pkg::mem_op_t  op;
        logic [ADDR_W-1:0] addr;
        mem_pkg::word_t    sdata;
        logic [WA_W-1:0]   taddr;
        mem_pkg::word_t    exp_data;
        logic              exp_fault;
        mem_pkg::word_t    exp_test;
    } row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              mem_read;
    logic              mem_write;
    mem_pkg::mem_op_t  mem_op;
    logic [ADDR_W-1:0] addr;
    mem_pkg::word_t    store_data;
    logic [WA_W-1:0]   test_addr;
    mem_pkg::word_t    test_data;
    mem_pkg::word_t    wb_data;
    logic              wb_valid;
    logic              wb_fault;

    row_t           rows[$];
    mem_pkg::word_t shadow [WORDS];   // Expected memory contents
    logic           table_ready = 1'b0;
    int             errors      = 0;
    int             pass_count  = 0;
    int             fail_count  = 0;

    mem_stage #(
        .WORDS      (WORDS)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_op     (mem_op),
        .addr       (addr),
        .store_data (store_data),
        .test_addr  (test_addr),
        .test_data  (test_data),
        .wb_data    (wb_data),
        .wb_valid   (wb_valid),
        .wb_fault   (wb_fault)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic is_aligned(input mem_pkg::mem_op_t op, input logic [1:0] off);
        case (op)
            mem_pkg::MEM_B, mem_pkg::MEM_BU: return 1'b1;
            mem_pkg::MEM_H, mem_pkg::MEM_HU: return off[0] == 1'b0;
            default:                         return off == 2'b00;
        endcase
    endfunction

    function automatic mem_pkg::word_t expected_load(input mem_pkg::word_t w,
                                                     input mem_pkg::mem_op_t op,
                                                     input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            mem_pkg::MEM_B:  return {{24{b[7]}}, b};
            mem_pkg::MEM_BU: return {24'h0, b};
            mem_pkg::MEM_H:  return {{16{h[15]}}, h};
            mem_pkg::MEM_HU: return {16'h0, h};
            default:         return w;
        endcase
    endfunction

    task automatic model_store(input logic [WA_W-1:0] wa, input mem_pkg::mem_op_t op,
                               input logic [1:0] off, input mem_pkg::word_t d);
        case (op)
            mem_pkg::MEM_B, mem_pkg::MEM_BU: shadow[wa][8*off +: 8]  = d[7:0];
            mem_pkg::MEM_H, mem_pkg::MEM_HU: shadow[wa][8*off +: 16] = d[15:0];
            default:                         shadow[wa]              = d;
        endcase
    endtask

    function automatic logic [ADDR_W-1:0] byte_addr(input int word, input int off);
        return ADDR_W'(word * 4 + off);
    endfunction

    // Expected values come from the shadow memory as the table is built
    task automatic add_row(input logic rd, input logic wr, input mem_pkg::mem_op_t op,
                           input logic [ADDR_W-1:0] a, input mem_pkg::word_t sdata,
                           input logic [WA_W-1:0] taddr);
        row_t            r;
        logic [WA_W-1:0] wa;
        logic [1:0]      off;
        logic            ok;
        wa          = a[ADDR_W-1:2];
        off         = a[1:0];
        ok          = is_aligned(op, off);
        r.rd        = rd;
        r.wr        = wr;
        r.op        = op;
        r.addr      = a;
        r.sdata     = sdata;
        r.taddr     = taddr;
        r.exp_data  = (rd && ok) ? expected_load(shadow[wa], op, off) : '0;
        r.exp_fault = rd && !ok;
        if (wr && ok)
        begin
            model_store(wa, op, off, sdata);
        end
        r.exp_test  = shadow[taddr];   // Seen after this row's write
        rows.push_back(r);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic build_table();
        // Fill every word, then read it all back
        for (int w = 0; w < WORDS; w++)
        begin
            add_row(1'b0, 1'b1, mem_pkg::MEM_W, byte_addr(w, 0), $urandom(), WA_W'(w));
        end
        for (int w = 0; w < WORDS; w++)
        begin
            add_row(1'b1, 1'b0, mem_pkg::MEM_W, byte_addr(w, 0), '0, WA_W'(WORDS - 1 - w));
        end
        // Byte stores, one lane at a time
        for (int off = 0; off < 4; off++)
        begin
            add_row(1'b0, 1'b1, mem_pkg::MEM_B, byte_addr(3, off), 32'h5555_5580 + off, 5'd3);
            add_row(1'b1, 1'b0, mem_pkg::MEM_W, byte_addr(3, 0), '0, 5'd3);
        end
        add_row(1'b0, 1'b1, mem_pkg::MEM_H,  byte_addr(5, 0), 32'hDEAD_BEEF, 5'd5);
        add_row(1'b1, 1'b0, mem_pkg::MEM_W,  byte_addr(5, 0), '0, 5'd5);
        add_row(1'b0, 1'b1, mem_pkg::MEM_HU, byte_addr(5, 2), 32'h1234_8765, 5'd5);
        add_row(1'b1, 1'b0, mem_pkg::MEM_W,  byte_addr(5, 0), '0, 5'd5);
        // Bytes and halves with top bit both set and clear
        add_row(1'b0, 1'b1, mem_pkg::MEM_W, byte_addr(6, 0), 32'h7ABC_8034, 5'd6);
        for (int off = 0; off < 4; off++)
        begin
            add_row(1'b1, 1'b0, mem_pkg::MEM_B,  byte_addr(6, off), '0, 5'd6);
            add_row(1'b1, 1'b0, mem_pkg::MEM_BU, byte_addr(6, off), '0, 5'd6);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            add_row(1'b1, 1'b0, mem_pkg::MEM_H,  byte_addr(6, off), '0, 5'd6);
            add_row(1'b1, 1'b0, mem_pkg::MEM_HU, byte_addr(6, off), '0, 5'd6);
        end
        // Misaligned loads and stores
        add_row(1'b1, 1'b0, mem_pkg::MEM_H,  byte_addr(6, 1), '0, 5'd6);
        add_row(1'b1, 1'b0, mem_pkg::MEM_HU, byte_addr(6, 3), '0, 5'd6);
        add_row(1'b1, 1'b0, mem_pkg::MEM_W,  byte_addr(7, 1), '0, 5'd7);
        add_row(1'b1, 1'b0, mem_pkg::MEM_W,  byte_addr(7, 2), '0, 5'd7);
        add_row(1'b1, 1'b0, mem_pkg::MEM_W,  byte_addr(7, 3), '0, 5'd7);
        add_row(1'b0, 1'b1, mem_pkg::MEM_H,  byte_addr(7, 1), 32'hFFFF_FFFF, 5'd7);
        add_row(1'b0, 1'b1, mem_pkg::MEM_W,  byte_addr(7, 2), 32'h0BAD_0BAD, 5'd7);
        add_row(1'b0, 1'b1, mem_pkg::MEM_HU, byte_addr(7, 3), 32'h0000_AAAA, 5'd7);
        add_row(1'b1, 1'b0, mem_pkg::MEM_W,  byte_addr(7, 0), '0, 5'd7);
        // Debug port on other words
        add_row(1'b0, 1'b1, mem_pkg::MEM_B,  byte_addr(10, 1), 32'h0000_00C3, 5'd20);
        add_row(1'b1, 1'b0, mem_pkg::MEM_HU, byte_addr(11, 2), '0, 5'd10);
        add_row(1'b0, 1'b0, mem_pkg::MEM_W,  byte_addr(0, 0), '0, 5'd0);
        add_row(1'b0, 1'b1, mem_pkg::MEM_W,  byte_addr(12, 0), 32'hCAFE_F00D, 5'd31);
        add_row(1'b1, 1'b0, mem_pkg::MEM_B,  byte_addr(12, 3), '0, 5'd12);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string what, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic log_result(input string name, input int errs_before);
        if (errors == errs_before)
        begin
            $display("%s ok", name);
            pass_count++;
        end
        else
        begin
            $display("%s failed", name);
            fail_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        int errs_before;
        rst_n      = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b1;            // Memory has no reset and takes this store
        mem_op     = mem_pkg::MEM_W;
        addr       = '0;
        store_data = 32'hA5A5_5A5A;
        test_addr  = '0;
        void'($urandom(32'h1998));
        build_table();
        table_ready = 1'b1;

        // Loads while reset is held must not reach the result registers
        @(posedge clk);
        #1;
        mem_write = 1'b0;
        mem_read  = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        errs_before = errors;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_word("wb_data", wb_data, '0);
        mem_op = mem_pkg::MEM_H;
        addr   = ADDR_W'(1);          // Misaligned halfword
        @(posedge clk);
        #1;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("wb_fault", wb_fault, 1'b0);
        mem_read = 1'b0;
        mem_op   = mem_pkg::MEM_W;
        addr     = '0;
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("wb_fault", wb_fault, 1'b0);
        check_word("wb_data", wb_data, '0);
        log_result("Reset values", errs_before);

        for (int i = 0; i < rows.size(); i++)
        begin
            errs_before = errors;
            mem_read    = rows[i].rd;
            mem_write   = rows[i].wr;
            mem_op      = rows[i].op;
            addr        = rows[i].addr;
            store_data  = rows[i].sdata;
            test_addr   = rows[i].taddr;
            @(posedge clk);
            #1;
            mem_read  = 1'b0;
            mem_write = 1'b0;
            if (rows[i].rd)
            begin
                if (wb_valid !== 1'b1)
                begin
                    $display("Row %0d: load gave no valid result one cycle after its strobe", i);
                    errors++;
                end
                else
                begin
                    check_word("wb_data", wb_data, rows[i].exp_data);
                    check_flag("wb_fault", wb_fault, rows[i].exp_fault);
                end
            end
            else
            begin
                check_flag("wb_valid", wb_valid, 1'b0);   // Store or idle
                check_flag("wb_fault", wb_fault, 1'b0);
            end
            check_word("test_data", test_data, rows[i].exp_test);
            log_result($sformatf("Row %0d %s", i, rows[i].rd ? "load" :
                                 (rows[i].wr ? "store" : "idle")), errs_before);
            @(posedge clk);
            #1;
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

    // Two cycles per row plus reset and margin
    initial
    begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (rows.size() * 2 + 8 + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the run did not complete", limit_ns);
        $display("test failed");
        $finish;
    end

endmodule

/* sources.f */
common/mem_pkg.sv
hw/mem_stage/mem_access_ctrl.sv
hw/mem_stage/data_ram.sv
hw/mem_stage/load_align.sv
hw/mem_stage/mem_stage.sv
testbench/mem_stage_assert.sv
testbench/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mem_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_mem_stage \
    -f sources.f

status=0
sim_out=$(./obj_dir/Vtb_mem_stage 2>&1) || status=$?
printf '%s\n' "$sim_out"

if [ "$status" -eq 0 ] && grep -qx "test passed" <<< "$sim_out"; then
    echo "Simulation PASSED"
    exit 0
fi

echo "Simulation FAILED"
exit 1
